// File: common/corePkg.sv
/* Core slice shared definitions */

package corePkg;

    // Widths that carry a meaning
    typedef logic [31:0] dataT;
    typedef logic [31:0] instrT;
    typedef logic [4:0]  regAddrT;
    typedef logic [3:0]  aluFuncT;
    typedef logic [5:0]  opCodeT;
    typedef logic [1:0]  immKindT;

    // ALU operation codes
    localparam aluFuncT aluAdd   = 4'd0;
    localparam aluFuncT aluSub   = 4'd1;
    localparam aluFuncT aluAnd   = 4'd2;
    localparam aluFuncT aluOr    = 4'd3;
    localparam aluFuncT aluXor   = 4'd4;
    localparam aluFuncT aluNor   = 4'd5;
    localparam aluFuncT aluSlt   = 4'd6;
    localparam aluFuncT aluSltu  = 4'd7;
    localparam aluFuncT aluSll   = 4'd8;
    localparam aluFuncT aluSrl   = 4'd9;
    localparam aluFuncT aluSra   = 4'd10;
    localparam aluFuncT aluPassB = 4'd11;

    // Primary opcodes
    localparam opCodeT opRType = 6'h00;
    localparam opCodeT opAddiu = 6'h09;
    localparam opCodeT opSlti  = 6'h0a;
    localparam opCodeT opSltiu = 6'h0b;
    localparam opCodeT opAndi  = 6'h0c;
    localparam opCodeT opOri   = 6'h0d;
    localparam opCodeT opXori  = 6'h0e;
    localparam opCodeT opLui   = 6'h0f;

    // R-type function field
    localparam opCodeT fnSll  = 6'h00;
    localparam opCodeT fnSrl  = 6'h02;
    localparam opCodeT fnSra  = 6'h03;
    localparam opCodeT fnAddu = 6'h21;
    localparam opCodeT fnSubu = 6'h23;
    localparam opCodeT fnAnd  = 6'h24;
    localparam opCodeT fnOr   = 6'h25;
    localparam opCodeT fnXor  = 6'h26;
    localparam opCodeT fnNor  = 6'h27;
    localparam opCodeT fnSlt  = 6'h2a;
    localparam opCodeT fnSltu = 6'h2b;

    // Immediate forms
    localparam immKindT immSign  = 2'd0;
    localparam immKindT immZero  = 2'd1;
    localparam immKindT immUpper = 2'd2;

    typedef struct packed {
        logic    regWrite;
        logic    aluSrc;
        logic    shiftVar;
        immKindT immKind;
        logic    regDst;
        aluFuncT aluFunc;
    } ctrlT;

    typedef struct packed {
        logic        valid;
        logic        regWrite;
        regAddrT     dest;
        aluFuncT     aluFunc;
        dataT        opA;
        dataT        opB;
        logic [4:0]  shamt;
    } exStageT;

    typedef struct packed {
        logic    valid;
        regAddrT dest;
        dataT    data;
    } wbStageT;

endpackage

// File: compile.f
common/corePkg.sv
decode/controlDecoder.sv
decode/registerFile.sv
decode/decodeStage.sv
src/aluUnit.sv
src/miniCore.sv
test/coreTb.sv

// File: decode/controlDecoder.sv
/* Instruction control decoder */

`timescale 1ns/1ps

module controlDecoder (
    input  corePkg::opCodeT opCode,
    input  corePkg::opCodeT funcIn,
    output corePkg::ctrlT   ctrl
);

    always_comb begin
        // Anything not listed below behaves as a no-op
        ctrl = '0;
        ctrl.aluFunc = corePkg::aluAdd;
        ctrl.immKind = corePkg::immSign;

        case (opCode)
            corePkg::opRType: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = 1'b1;
                case (funcIn)
                    corePkg::fnAddu: ctrl.aluFunc = corePkg::aluAdd;
                    corePkg::fnSubu: ctrl.aluFunc = corePkg::aluSub;
                    corePkg::fnAnd:  ctrl.aluFunc = corePkg::aluAnd;
                    corePkg::fnOr:   ctrl.aluFunc = corePkg::aluOr;
                    corePkg::fnXor:  ctrl.aluFunc = corePkg::aluXor;
                    corePkg::fnNor:  ctrl.aluFunc = corePkg::aluNor;
                    corePkg::fnSlt:  ctrl.aluFunc = corePkg::aluSlt;
                    corePkg::fnSltu: ctrl.aluFunc = corePkg::aluSltu;
                    corePkg::fnSll: begin
                        ctrl.aluFunc  = corePkg::aluSll;
                        ctrl.shiftVar = 1'b1;
                    end
                    corePkg::fnSrl: begin
                        ctrl.aluFunc  = corePkg::aluSrl;
                        ctrl.shiftVar = 1'b1;
                    end
                    corePkg::fnSra: begin
                        ctrl.aluFunc  = corePkg::aluSra;
                        ctrl.shiftVar = 1'b1;
                    end
                    default: begin
                        ctrl.regWrite = 1'b0;
                        ctrl.regDst   = 1'b0;
                    end
                endcase
            end

            corePkg::opAddiu: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluFunc  = corePkg::aluAdd;
            end

            corePkg::opSlti: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluFunc  = corePkg::aluSlt;
            end

            // Unsigned compare against the zero-extended value
            corePkg::opSltiu: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.immKind  = corePkg::immZero;
                ctrl.aluFunc  = corePkg::aluSltu;
            end

            corePkg::opAndi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.immKind  = corePkg::immZero;
                ctrl.aluFunc  = corePkg::aluAnd;
            end

            corePkg::opOri: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.immKind  = corePkg::immZero;
                ctrl.aluFunc  = corePkg::aluOr;
            end

            corePkg::opXori: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.immKind  = corePkg::immZero;
                ctrl.aluFunc  = corePkg::aluXor;
            end

            // Upper half comes straight through the B side
            corePkg::opLui: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.immKind  = corePkg::immUpper;
                ctrl.aluFunc  = corePkg::aluPassB;
            end

            default: ctrl = '0;
        endcase
    end

endmodule

// File: decode/decodeStage.sv
/* Decode stage with operand forwarding */

`timescale 1ns/1ps

module decodeStage (
    input  logic             Clock,
    input  logic             reset,
    input  logic             instrValid,
    input  corePkg::instrT   instruction,
    input  corePkg::wbStageT exFwd,
    input  corePkg::wbStageT wbFwd,
    output corePkg::exStageT exNext,
    input  corePkg::regAddrT regAddr,
    output corePkg::dataT    regData
);

    corePkg::ctrlT    ctrl;
    corePkg::regAddrT rsAddr;
    corePkg::regAddrT rtAddr;
    corePkg::regAddrT rdAddr;
    corePkg::regAddrT dest;
    logic [4:0]       shamt;
    logic [15:0]      offset;
    corePkg::opCodeT  func;
    corePkg::dataT    immData;
    corePkg::dataT    rsFile;
    corePkg::dataT    rtFile;
    corePkg::dataT    rsValue;
    corePkg::dataT    rtValue;

    // Youngest producer wins, register 0 is never forwarded
    function automatic corePkg::dataT pickOperand(
        input corePkg::regAddrT addr,
        input corePkg::dataT    fileData,
        input corePkg::wbStageT exStage,
        input corePkg::wbStageT wbStage
    );
        corePkg::dataT value;
        value = fileData;
        if (addr == '0) begin
            value = '0;
        end else if (exStage.valid && exStage.dest == addr) begin
            value = exStage.data;
        end else if (wbStage.valid && wbStage.dest == addr) begin
            value = wbStage.data;
        end
        return value;
    endfunction

    assign rsAddr = instruction[25:21];
    assign rtAddr = instruction[20:16];
    assign rdAddr = instruction[15:11];
    assign shamt  = instruction[10:6];
    assign offset = instruction[15:0];
    assign func   = instruction[5:0];

    controlDecoder controlDecoder_i (
        .opCode (instruction[31:26]),
        .funcIn (func),
        .ctrl   (ctrl)
    );

    // Write port is fed by the writeback register
    registerFile registerFile_i (
        .Clock    (Clock),
        .reset    (reset),
        .regWrite (wbFwd.valid),
        .rdAddr   (wbFwd.dest),
        .rdData   (wbFwd.data),
        .rsAddr   (rsAddr),
        .rtAddr   (rtAddr),
        .rsData   (rsFile),
        .rtData   (rtFile),
        .regAddr  (regAddr),
        .regData  (regData)
    );

    always_comb begin
        case (ctrl.immKind)
            corePkg::immZero:  immData = {16'h0000, offset};
            corePkg::immUpper: immData = {offset, 16'h0000};
            default:           immData = {{16{offset[15]}}, offset};
        endcase
    end

    assign dest    = ctrl.regDst ? rdAddr : rtAddr;
    assign rsValue = pickOperand(rsAddr, rsFile, exFwd, wbFwd);
    assign rtValue = pickOperand(rtAddr, rtFile, exFwd, wbFwd);

    always_comb begin
        exNext.valid    = instrValid;
        exNext.regWrite = instrValid && ctrl.regWrite && (dest != '0);
        exNext.dest     = dest;
        exNext.aluFunc  = ctrl.aluFunc;
        exNext.opA      = rsValue;
        exNext.opB      = ctrl.aluSrc ? immData : rtValue;
        exNext.shamt    = ctrl.shiftVar ? shamt : 5'd0;
    end

endmodule

// File: decode/registerFile.sv
/* Register file with debug port */

`timescale 1ns/1ps

module registerFile (
    input  logic             Clock,
    input  logic             reset,
    input  logic             regWrite,
    input  corePkg::regAddrT rdAddr,
    input  corePkg::dataT    rdData,
    input  corePkg::regAddrT rsAddr,
    input  corePkg::regAddrT rtAddr,
    output corePkg::dataT    rsData,
    output corePkg::dataT    rtData,
    input  corePkg::regAddrT regAddr,
    output corePkg::dataT    regData
);

    // Register 0 has no storage
    corePkg::dataT regs [1:31];

    always_ff @(posedge Clock) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && rdAddr != '0) begin
            regs[rdAddr] <= rdData;
        end
    end

    assign rsData  = (rsAddr == '0) ? '0 : regs[rsAddr];
    assign rtData  = (rtAddr == '0) ? '0 : regs[rtAddr];

    // Debug read, combinational
    assign regData = (regAddr == '0) ? '0 : regs[regAddr];

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the core slice testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert -sv --top-module coreTb \
    -f compile.f --Mdir "$buildDir" -o coreSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "verilator build failed with status $buildStatus"
    exit 1
fi

"./$buildDir/coreSim" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -qx '>>> PASS' "$logFile"; then
    exit 0
fi
echo "pass message not found in $logFile"
exit 1

// File: src/aluUnit.sv
/* Execute stage ALU */

`timescale 1ns/1ps

module aluUnit (
    input  logic             Clock,
    input  logic             reset,
    input  corePkg::exStageT exNext,
    output corePkg::wbStageT result
);

    corePkg::exStageT exReg;
    corePkg::dataT    aluOut;

    // Operands carry no reset, only the valid bits do
    always_ff @(posedge Clock) begin
        exReg <= exNext;
        if (reset) begin
            exReg.valid    <= 1'b0;
            exReg.regWrite <= 1'b0;
        end
    end

    always_comb begin
        case (exReg.aluFunc)
            corePkg::aluAdd:   aluOut = exReg.opA + exReg.opB;
            corePkg::aluSub:   aluOut = exReg.opA - exReg.opB;
            corePkg::aluAnd:   aluOut = exReg.opA & exReg.opB;
            corePkg::aluOr:    aluOut = exReg.opA | exReg.opB;
            corePkg::aluXor:   aluOut = exReg.opA ^ exReg.opB;
            corePkg::aluNor:   aluOut = ~(exReg.opA | exReg.opB);
            corePkg::aluSlt: begin
                aluOut = {31'd0, $signed(exReg.opA) < $signed(exReg.opB)};
            end
            corePkg::aluSltu: begin
                aluOut = {31'd0, exReg.opA < exReg.opB};
            end
            // Shifts act on rt, which sits on the B side
            corePkg::aluSll:   aluOut = exReg.opB << exReg.shamt;
            corePkg::aluSrl:   aluOut = exReg.opB >> exReg.shamt;
            corePkg::aluSra: begin
                aluOut = corePkg::dataT'($signed(exReg.opB) >>> exReg.shamt);
            end
            corePkg::aluPassB: aluOut = exReg.opB;
            default:           aluOut = '0;
        endcase
    end

    always_comb begin
        result.valid = exReg.valid && exReg.regWrite;
        result.dest  = exReg.dest;
        result.data  = aluOut;
    end

    // Decoder must never hand over an undefined operation
    knownFunc: assert property (@(posedge Clock) disable iff (reset)
        exReg.valid |-> (exReg.aluFunc <= corePkg::aluPassB));

    // A write to r0 never reaches this stage
    noZeroWrite: assert property (@(posedge Clock) disable iff (reset)
        (exReg.valid && exReg.regWrite) |-> (exReg.dest != '0));

endmodule

// File: src/miniCore.sv
/* Integer core slice top */

`timescale 1ns/1ps

module miniCore (
    input  logic             Clock,
    input  logic             reset,
    input  logic             instrValid,
    input  corePkg::instrT   instruction,
    output logic             retireValid,
    output corePkg::regAddrT retireAddr,
    output corePkg::dataT    retireData,
    input  corePkg::regAddrT regAddr,
    output corePkg::dataT    regData
);

    corePkg::exStageT exNext;
    corePkg::wbStageT aluResult;
    corePkg::wbStageT wbReg;

    decodeStage decodeStage_i (
        .Clock       (Clock),
        .reset       (reset),
        .instrValid  (instrValid),
        .instruction (instruction),
        .exFwd       (aluResult),
        .wbFwd       (wbReg),
        .exNext      (exNext),
        .regAddr     (regAddr),
        .regData     (regData)
    );

    aluUnit aluUnit_i (
        .Clock  (Clock),
        .reset  (reset),
        .exNext (exNext),
        .result (aluResult)
    );

    // Writeback register, also the second forwarding source
    always_ff @(posedge Clock) begin
        wbReg <= aluResult;
        if (reset) begin
            wbReg.valid <= 1'b0;
        end
    end

    assign retireValid = wbReg.valid;
    assign retireAddr  = wbReg.dest;
    assign retireData  = wbReg.data;

    // After a retire the debug port sees the new value one edge later
    retireLands: assert property (@(posedge Clock) disable iff (reset)
        (retireValid && regAddr == retireAddr) ##1 (regAddr == $past(retireAddr))
            |-> (regData == $past(retireData)));

endmodule

// File: test/coreTb.sv
/* Core slice testbench */

`timescale 1ns/1ps

module coreTb;

    typedef struct packed {
        corePkg::regAddrT addr;
        corePkg::dataT    data;
        logic [31:0]      due;
    } retireT;

    // Random test takes at most 600 cycles with a gap before every instruction
    // Reset, directed tests, drains and debug sweeps add about 360
    localparam int stimulusCycles = 960;
    localparam int timeoutLimit   = stimulusCycles + 200;

    logic             Clock = 1'b0;
    logic             reset;
    logic             instrValid;
    corePkg::instrT   instruction;
    logic             retireValid;
    corePkg::regAddrT retireAddr;
    corePkg::dataT    retireData;
    corePkg::regAddrT regAddr;
    corePkg::dataT    regData;

    corePkg::dataT refRegs [0:31];
    retireT        expQ [$];
    retireT        head;
    logic          headValid;
    logic          readCheck;
    corePkg::dataT readExpect;
    logic [31:0]   cycleCount = '0;
    integer        seed = 74934;
    int            errorCount = 0;
    int            errorsAtStart = 0;
    int            passCount = 0;
    int            failCount = 0;

    corePkg::opCodeT rFuncs [11] = '{corePkg::fnAddu, corePkg::fnSubu, corePkg::fnAnd,
        corePkg::fnOr, corePkg::fnXor, corePkg::fnNor, corePkg::fnSlt, corePkg::fnSltu,
        corePkg::fnSll, corePkg::fnSrl, corePkg::fnSra};
    corePkg::opCodeT iOps [7] = '{corePkg::opAddiu, corePkg::opSlti, corePkg::opSltiu,
        corePkg::opAndi, corePkg::opOri, corePkg::opXori, corePkg::opLui};

    miniCore miniCore_i (
        .Clock       (Clock),
        .reset       (reset),
        .instrValid  (instrValid),
        .instruction (instruction),
        .retireValid (retireValid),
        .retireAddr  (retireAddr),
        .retireData  (retireData),
        .regAddr     (regAddr),
        .regData     (regData)
    );

    always #20 Clock = ~Clock;

    always @(posedge Clock) begin
        cycleCount <= cycleCount + 32'd1;
        if (cycleCount >= timeoutLimit) begin
            $display("timeout: run did not finish within %0d cycles", timeoutLimit);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic refreshHead;
        headValid = (expQ.size() > 0);
        head      = headValid ? expQ[0] : '0;
    endtask

    // Drop the head once its retire slot has been checked
    always @(posedge Clock) begin
        if (headValid && head.due <= cycleCount) begin
            void'(expQ.pop_front());
            refreshHead();
        end
    end

    task automatic reportRetire;
        if (!headValid || head.due != cycleCount) begin
            $display("error %0t: unexpected retire to r%0d", $time, retireAddr);
        end else begin
            $display("error %0t: retire r%0d = %h, expected r%0d = %h", $time,
                retireAddr, retireData, head.addr, head.data);
        end
    endtask

    // Outputs are sampled mid-cycle, away from the edge they change on
    retireMatches: assert property (@(negedge Clock) disable iff (reset)
        retireValid |-> (headValid && head.due == cycleCount &&
            retireAddr == head.addr && retireData == head.data))
        else begin
            errorCount++;
            reportRetire();
        end

    retireOnTime: assert property (@(negedge Clock) disable iff (reset)
        (headValid && head.due == cycleCount) |-> retireValid)
        else begin
            errorCount++;
            $display("missing retire: r%0d was not written back at %0t", head.addr, $time);
        end

    debugReadMatches: assert property (@(negedge Clock) disable iff (reset)
        readCheck |-> (regData == readExpect))
        else begin
            errorCount++;
            $display("error %0t: debug read r%0d = %h, expected %h", $time,
                regAddr, regData, readExpect);
        end

    function automatic corePkg::instrT rType(input corePkg::opCodeT fn, input int rd,
        input int rs, input int rt, input int sh);
        return {corePkg::opRType, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic corePkg::instrT iType(input corePkg::opCodeT op, input int rt,
        input int rs, input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    // ISA reference, applied in program order
    task automatic modelInstr(input corePkg::instrT instr);
        corePkg::dataT    a;
        corePkg::dataT    b;
        corePkg::dataT    sImm;
        corePkg::dataT    zImm;
        corePkg::dataT    value;
        corePkg::regAddrT dest;
        logic [4:0]       sh;
        logic             writes;
        a      = refRegs[instr[25:21]];
        b      = refRegs[instr[20:16]];
        sh     = instr[10:6];
        sImm   = {{16{instr[15]}}, instr[15:0]};
        zImm   = {16'h0000, instr[15:0]};
        writes = 1'b1;
        dest   = instr[20:16];
        value  = '0;
        if (instr[31:26] == 6'h00) begin
            dest = instr[15:11];
            case (instr[5:0])
                6'h21:   value = a + b;
                6'h23:   value = a - b;
                6'h24:   value = a & b;
                6'h25:   value = a | b;
                6'h26:   value = a ^ b;
                6'h27:   value = ~(a | b);
                6'h2a:   value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                6'h2b:   value = (a < b) ? 32'd1 : 32'd0;
                6'h00:   value = b << sh;
                6'h02:   value = b >> sh;
                6'h03:   value = $unsigned($signed(b) >>> sh);
                default: writes = 1'b0;
            endcase
        end else begin
            case (instr[31:26])
                6'h09:   value = a + sImm;
                6'h0a:   value = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
                6'h0b:   value = (a < zImm) ? 32'd1 : 32'd0;
                6'h0c:   value = a & zImm;
                6'h0d:   value = a | zImm;
                6'h0e:   value = a ^ zImm;
                6'h0f:   value = {instr[15:0], 16'h0000};
                default: writes = 1'b0;
            endcase
        end
        if (writes && dest != 5'd0) begin
            refRegs[dest] = value;
            // Sampled next edge, in wbReg one edge later, checked in that cycle
            expQ.push_back(retireT'{addr: dest, data: value, due: cycleCount + 32'd3});
            refreshHead();
        end
    endtask

    task automatic issue(input corePkg::instrT instr);
        @(posedge Clock);
        instrValid  <= 1'b1;
        instruction <= instr;
        modelInstr(instr);
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge Clock);
            instrValid  <= 1'b0;
            instruction <= $random(seed);
        end
    endtask

    task automatic loadConst(input int r, input corePkg::dataT value);
        issue(iType(corePkg::opLui, r, 0, value[31:16]));
        issue(iType(corePkg::opOri, r, r, value[15:0]));
    endtask

    // Wait for every expected retire, then for the register file write
    task automatic drain;
        idleCycles(1);
        while (headValid) begin
            @(posedge Clock);
        end
        idleCycles(3);
    endtask

    task automatic sweepRegs;
        for (int i = 0; i < 32; i++) begin
            @(posedge Clock);
            regAddr    <= corePkg::regAddrT'(i);
            readExpect <= refRegs[i];
            readCheck  <= 1'b1;
        end
        @(posedge Clock);
        readCheck <= 1'b0;
    endtask

    // Each step reads results 1, 2 and 3 instructions back
    task automatic runChain(input int base, input logic [15:0] start, input int spacing);
        issue(iType(corePkg::opAddiu, base, 0, start));
        idleCycles(spacing);
        issue(iType(corePkg::opAddiu, base + 1, base, 16'd100));
        idleCycles(spacing);
        issue(rType(corePkg::fnAddu, base + 2, base, base + 1, 0));
        idleCycles(spacing);
        issue(rType(corePkg::fnSubu, base + 3, base + 2, base, 0));
        idleCycles(spacing);
        issue(rType(corePkg::fnXor, base + 4, base + 3, base + 1, 0));
        idleCycles(spacing);
        issue(rType(corePkg::fnOr, base + 5, base + 4, base + 3, 0));
        idleCycles(spacing);
        issue(rType(corePkg::fnSll, base + 6, 0, base + 5, 3));
        drain();
        sweepRegs();
    endtask

    task automatic randomInstr(output corePkg::instrT instr);
        int kind;
        kind = {$random(seed)} % 18;
        if (kind < 11) begin
            instr = rType(rFuncs[kind], {$random(seed)} % 8, {$random(seed)} % 8,
                {$random(seed)} % 8, {$random(seed)} % 32);
        end else begin
            instr = iType(iOps[kind - 11], {$random(seed)} % 8, {$random(seed)} % 8,
                16'($random(seed)));
        end
    endtask

    task automatic endTest(input string name);
        if (errorCount == errorsAtStart) begin
            passCount++;
            $display("test %s: ok", name);
        end else begin
            failCount++;
            $display("test %s: %0d errors", name, errorCount - errorsAtStart);
        end
        errorsAtStart = errorCount;
    endtask

    initial begin
        corePkg::instrT instr;
        reset       = 1'b1;
        instrValid  = 1'b0;
        instruction = '0;
        regAddr     = '0;
        readCheck   = 1'b0;
        readExpect  = '0;
        for (int i = 0; i < 32; i++) begin
            refRegs[i] = '0;
        end
        refreshHead();
        repeat (16) @(posedge Clock);
        reset <= 1'b0;

        sweepRegs();
        endTest("reset");

        loadConst(1, 32'h8765_4321);
        loadConst(2, 32'h0000_00f0);
        loadConst(3, 32'h1234_5678);
        for (int i = 0; i < 11; i++) begin
            issue(rType(rFuncs[i], 4 + i, 2, 1, 7));
        end
        drain();
        sweepRegs();
        endTest("rtype");

        issue(iType(corePkg::opAddiu, 15, 1, 16'hfff0));
        issue(iType(corePkg::opSlti, 16, 2, 16'hffff));
        issue(iType(corePkg::opSlti, 17, 1, 16'h0005));
        issue(iType(corePkg::opSltiu, 18, 3, 16'hffff));
        issue(iType(corePkg::opSltiu, 19, 2, 16'h8000));
        issue(iType(corePkg::opAndi, 20, 1, 16'hff00));
        issue(iType(corePkg::opOri, 21, 0, 16'h8001));
        issue(iType(corePkg::opXori, 22, 1, 16'hffff));
        issue(iType(corePkg::opLui, 23, 0, 16'hbeef));
        drain();
        sweepRegs();
        endTest("immediate");

        runChain(24, 16'd3, 4);
        runChain(24, 16'd77, 0);
        endTest("forwarding");

        issue(iType(corePkg::opAddiu, 0, 1, 16'h0005));
        issue(rType(corePkg::fnAddu, 30, 0, 0, 0));
        issue(rType(corePkg::fnOr, 0, 1, 2, 0));
        issue(iType(6'h23, 5, 1, 16'h0010));
        issue(iType(6'h04, 6, 1, 16'h0002));
        issue(rType(6'h18, 7, 1, 2, 0));
        issue(rType(6'h08, 8, 1, 0, 0));
        drain();
        sweepRegs();
        endTest("zero and unsupported");

        for (int n = 0; n < 300; n++) begin
            if ({$random(seed)} % 4 == 0) begin
                idleCycles(1);
            end
            randomInstr(instr);
            issue(instr);
        end
        drain();
        sweepRegs();
        endTest("random");

        $display("tests passed %0d, failed %0d, errors %0d", passCount, failCount,
            errorCount);
        if (errorCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
